//--- rtab_cfg_pkg.sv
// Replay table geometry and payload types
package rtab_cfg_pkg;

    localparam int RTAB_ENTRIES = 4;

    localparam int NLINE_WIDTH  = 8;
    localparam int OFFSET_WIDTH = 4;
    localparam int TAG_ID_WIDTH = 8;

    typedef logic [$clog2(RTAB_ENTRIES)-1:0] rtab_ptr_t;
    typedef logic [RTAB_ENTRIES-1:0]         rtab_bv_t;

    typedef logic [NLINE_WIDTH-1:0]               rtab_nline_t;
    typedef logic [NLINE_WIDTH+OFFSET_WIDTH-1:0]  rtab_addr_t;
    typedef logic [TAG_ID_WIDTH-1:0]              rtab_tag_t;

    // Address in the upper bits, requester tag in the lower bits
    typedef logic [$bits(rtab_addr_t)+$bits(rtab_tag_t)-1:0] rtab_req_t;

    // Lowest set bit wins
    function automatic rtab_ptr_t rtab_bv_to_ptr(input rtab_bv_t bv);
        rtab_ptr_t ptr;
        ptr = '0;
        for (int i = RTAB_ENTRIES - 1; i >= 0; i--) begin
            if (bv[i]) begin
                ptr = rtab_ptr_t'(i);
            end
        end
        return ptr;
    endfunction

    function automatic rtab_bv_t rtab_ptr_to_bv(input rtab_ptr_t ptr);
        return rtab_bv_t'(1) << ptr;
    endfunction

endpackage

//--- rtab_dep_pkg.sv
// Replay table dependency kinds
package rtab_dep_pkg;

    // Pending miss on the same line, released by a refill of that line
    localparam int DEP_MSHR_HIT   = 0;

    // Miss handler not ready, released by the miss-ready level
    localparam int DEP_MISS_READY = 1;

    // Flush in progress on the line, released by its flush acknowledge
    localparam int DEP_FLUSH_HIT  = 2;

    localparam int NUM_DEPS = 3;

    // One flag per dependency kind
    typedef logic [NUM_DEPS-1:0] rtab_deps_t;

endpackage

//--- rtab_entry_store.sv
// Replay table entry storage
`timescale 1ns/1ns
`default_nettype none

module rtab_entry_store (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,

    input  rtab_cfg_pkg::rtab_nline_t                           check_nline_i,
    output logic                                                check_hit_o,

    input  logic                                                alloc_i,
    input  logic                                                alloc_link_i,
    input  rtab_cfg_pkg::rtab_req_t                             alloc_req_i,

    input  rtab_cfg_pkg::rtab_bv_t                              pop_try_bv_i,
    input  rtab_cfg_pkg::rtab_ptr_t                             pop_sel_ptr_i,
    input  logic                                                pop_commit_i,
    input  rtab_cfg_pkg::rtab_ptr_t                             pop_commit_ptr_i,
    input  logic                                                pop_rback_i,
    input  rtab_cfg_pkg::rtab_ptr_t                             pop_rback_ptr_i,

    output logic                                                empty_o,
    output logic                                                full_o,
    output rtab_cfg_pkg::rtab_bv_t                              valid_o,
    output rtab_cfg_pkg::rtab_bv_t                              head_o,
    output rtab_cfg_pkg::rtab_bv_t                              tail_o,
    output rtab_cfg_pkg::rtab_bv_t                              alloc_bv_o,
    output rtab_cfg_pkg::rtab_ptr_t   [rtab_cfg_pkg::RTAB_ENTRIES-1:0] next_o,
    output rtab_cfg_pkg::rtab_nline_t [rtab_cfg_pkg::RTAB_ENTRIES-1:0] nline_o,
    output rtab_cfg_pkg::rtab_req_t                             pop_req_o
);

    import rtab_cfg_pkg::*;

    rtab_req_t [RTAB_ENTRIES-1:0] req_q;
    rtab_ptr_t [RTAB_ENTRIES-1:0] next_q;

    rtab_bv_t valid_q;
    rtab_bv_t head_q;
    rtab_bv_t tail_q;
    rtab_bv_t head_set;
    rtab_bv_t head_rst;
    rtab_bv_t tail_rst;
    rtab_bv_t free;
    rtab_bv_t match_nline;
    rtab_bv_t match_tail;
    rtab_bv_t commit_bv;
    rtab_bv_t rback_bv;
    logic     alloc;

    // Lowest free entry as a one-hot vector
    assign free       = ~valid_q;
    assign alloc      = alloc_i | alloc_link_i;
    assign alloc_bv_o = free & (~free + 1'b1) & {RTAB_ENTRIES{alloc}};

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

    for (genvar i = 0; i < RTAB_ENTRIES; i++) begin : gen_line
        assign nline_o[i]     = req_q[i][TAG_ID_WIDTH + OFFSET_WIDTH +: NLINE_WIDTH];
        assign match_nline[i] = (nline_o[i] == check_nline_i);
    end

    assign check_hit_o = |(valid_q & match_nline);
    assign match_tail  = valid_q & match_nline & tail_q;

    assign commit_bv = rtab_ptr_to_bv(pop_commit_ptr_i) & {RTAB_ENTRIES{pop_commit_i}};
    assign rback_bv  = rtab_ptr_to_bv(pop_rback_ptr_i) & {RTAB_ENTRIES{pop_rback_i}};

    // A linked entry is reached through its predecessor, never as a head
    assign head_set = (alloc_bv_o & {RTAB_ENTRIES{alloc_i}}) | rback_bv;
    assign head_rst = (alloc_bv_o & {RTAB_ENTRIES{alloc_link_i}}) | pop_try_bv_i;
    assign tail_rst = match_tail & {RTAB_ENTRIES{alloc_link_i}};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q <= '0;
            head_q  <= '0;
            tail_q  <= '0;
            next_q  <= '0;
        end else begin
            valid_q <= (valid_q & ~commit_bv) | alloc_bv_o;
            head_q  <= (head_q & ~head_rst) | head_set;
            tail_q  <= (tail_q & ~tail_rst) | alloc_bv_o;
            for (int i = 0; i < RTAB_ENTRIES; i++) begin
                if (alloc_link_i && match_tail[i]) begin
                    next_q[i] <= rtab_bv_to_ptr(alloc_bv_o);
                end
            end
        end
    end

    // Payload is written once, at allocation
    always_ff @(posedge clk_i) begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (alloc_bv_o[i]) begin
                req_q[i] <= alloc_req_i;
            end
        end
    end

    assign valid_o   = valid_q;
    assign head_o    = head_q;
    assign tail_o    = tail_q;
    assign next_o    = next_q;
    assign pop_req_o = req_q[pop_sel_ptr_i];

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc_link_i |-> $onehot0(match_tail))
    else $error("rtab store: more than one tail matches the checked line");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        alloc |-> !full_o)
    else $error("rtab store: allocation while the table is full");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (!pop_commit_i || valid_q[pop_commit_ptr_i]) &&
        (!pop_rback_i || valid_q[pop_rback_ptr_i]))
    else $error("rtab store: commit or rollback of an invalid entry");

endmodule

`default_nettype wire

//--- rtab_dep_tracker.sv
// Replay table dependency tracking
`timescale 1ns/1ns
`default_nettype none

module rtab_dep_tracker (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,

    input  rtab_cfg_pkg::rtab_bv_t                              alloc_bv_i,
    input  rtab_dep_pkg::rtab_deps_t                            alloc_deps_i,
    input  rtab_cfg_pkg::rtab_nline_t [rtab_cfg_pkg::RTAB_ENTRIES-1:0] nline_i,

    input  logic                                                pop_rback_i,
    input  rtab_cfg_pkg::rtab_ptr_t                             pop_rback_ptr_i,

    input  logic                                                miss_ready_i,
    input  logic                                                refill_i,
    input  rtab_cfg_pkg::rtab_nline_t                           refill_nline_i,
    input  logic                                                flush_ack_i,
    input  rtab_cfg_pkg::rtab_nline_t                           flush_ack_nline_i,

    output rtab_cfg_pkg::rtab_bv_t                              nodeps_o
);

    import rtab_cfg_pkg::*;
    import rtab_dep_pkg::*;

    rtab_deps_t [RTAB_ENTRIES-1:0] deps_q;
    rtab_deps_t [RTAB_ENTRIES-1:0] deps_clr;
    rtab_bv_t                      load_bv;

    // A rollback re-arms the flags from the allocate-side inputs
    assign load_bv = alloc_bv_i |
                     (rtab_ptr_to_bv(pop_rback_ptr_i) & {RTAB_ENTRIES{pop_rback_i}});

    always_comb begin
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            deps_clr[i]                 = '0;
            deps_clr[i][DEP_MSHR_HIT]   = refill_i & (refill_nline_i == nline_i[i]);
            // Miss handler readiness is global to all entries
            deps_clr[i][DEP_MISS_READY] = miss_ready_i;
            deps_clr[i][DEP_FLUSH_HIT]  = flush_ack_i & (flush_ack_nline_i == nline_i[i]);
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            deps_q <= '0;
        end else begin
            for (int i = 0; i < RTAB_ENTRIES; i++) begin
                if (load_bv[i]) begin
                    deps_q[i] <= alloc_deps_i;
                end else begin
                    deps_q[i] <= deps_q[i] & ~deps_clr[i];
                end
            end
        end
    end

    for (genvar i = 0; i < RTAB_ENTRIES; i++) begin : gen_nodeps
        assign nodeps_o[i] = ~|deps_q[i];
    end

    // Both events share the allocate-side dependency inputs
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (|alloc_bv_i) |-> !pop_rback_i)
    else $error("rtab deps: allocation during a rollback");

endmodule

`default_nettype wire

//--- rtab_pop_ctrl.sv
// Replay table pop control
`timescale 1ns/1ns
`default_nettype none

module rtab_pop_ctrl (
    input  logic                                                clk_i,
    input  logic                                                rst_ni,

    input  rtab_cfg_pkg::rtab_bv_t                              valid_i,
    input  rtab_cfg_pkg::rtab_bv_t                              head_i,
    input  rtab_cfg_pkg::rtab_bv_t                              tail_i,
    input  rtab_cfg_pkg::rtab_bv_t                              nodeps_i,
    input  rtab_cfg_pkg::rtab_ptr_t [rtab_cfg_pkg::RTAB_ENTRIES-1:0] next_i,

    input  logic                                                pop_try_i,
    input  logic                                                pop_rback_i,

    output logic                                                pop_try_valid_o,
    output rtab_cfg_pkg::rtab_ptr_t                             pop_try_ptr_o,
    output rtab_cfg_pkg::rtab_bv_t                              pop_try_bv_o
);

    import rtab_cfg_pkg::*;

    typedef enum logic [1:0] {
        POP_TRY_HEAD,
        POP_TRY_NEXT,
        POP_TRY_NEXT_WAIT
    } pop_state_e;

    pop_state_e state_q;
    pop_state_e state_d;
    rtab_bv_t   next_bv_q;
    rtab_bv_t   next_bv_d;
    rtab_ptr_t  rr_ptr_q;
    rtab_ptr_t  rr_cand;
    rtab_bv_t   ready;
    rtab_bv_t   rr_gnt;
    rtab_bv_t   pop_sel;
    logic       pop_head;

    assign ready = valid_i & head_i & nodeps_i;

    // Search starts just after the last accepted head
    always_comb begin
        rr_gnt  = '0;
        rr_cand = '0;
        for (int k = 1; k <= RTAB_ENTRIES; k++) begin
            rr_cand = rtab_ptr_t'(rr_ptr_q + rtab_ptr_t'(k));
            if (rr_gnt == '0 && ready[rr_cand]) begin
                rr_gnt = rtab_ptr_to_bv(rr_cand);
            end
        end
    end

    assign pop_try_valid_o = (state_q == POP_TRY_HEAD) ? |ready : 1'b1;

    always_comb begin
        state_d   = state_q;
        next_bv_d = next_bv_q;
        pop_head  = 1'b0;
        pop_sel   = rr_gnt;

        case (state_q)
            POP_TRY_HEAD: begin
                if (!pop_rback_i && pop_try_valid_o && pop_try_i) begin
                    pop_head = 1'b1;
                    if ((rr_gnt & ~tail_i) != '0) begin
                        state_d   = POP_TRY_NEXT;
                        next_bv_d = rtab_ptr_to_bv(next_i[pop_try_ptr_o]);
                    end
                end
            end
            POP_TRY_NEXT, POP_TRY_NEXT_WAIT: begin
                pop_sel = next_bv_q;
                // The previous entry of the list went back to being a head
                if (state_q == POP_TRY_NEXT && pop_rback_i) begin
                    state_d = POP_TRY_HEAD;
                end else if (pop_try_i) begin
                    if ((next_bv_q & ~tail_i) != '0) begin
                        state_d   = POP_TRY_NEXT;
                        next_bv_d = rtab_ptr_to_bv(next_i[pop_try_ptr_o]);
                    end else begin
                        state_d = POP_TRY_HEAD;
                    end
                end else begin
                    state_d = POP_TRY_NEXT_WAIT;
                end
            end
            default: begin
                state_d = POP_TRY_HEAD;
            end
        endcase
    end

    assign pop_try_ptr_o = rtab_bv_to_ptr(pop_sel);
    assign pop_try_bv_o  = pop_sel & {RTAB_ENTRIES{pop_try_i}};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= POP_TRY_HEAD;
            next_bv_q <= '0;
            rr_ptr_q  <= rtab_ptr_t'(RTAB_ENTRIES - 1);
        end else begin
            state_q   <= state_d;
            next_bv_q <= next_bv_d;
            if (pop_head) begin
                rr_ptr_q <= pop_try_ptr_o;
            end
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop_try_i |-> !pop_rback_i)
    else $error("rtab pop: pop try during a rollback");

endmodule

`default_nettype wire

//--- rtab_top.sv
// Replay table top level
`timescale 1ns/1ns
`default_nettype none

module rtab_top (
    input  logic                      clk_i,
    input  logic                      rst_ni,

    input  logic                      check_i,
    input  rtab_cfg_pkg::rtab_nline_t check_nline_i,
    output logic                      check_hit_o,

    input  logic                      alloc_i,
    input  logic                      alloc_link_i,
    input  rtab_cfg_pkg::rtab_req_t   alloc_req_i,
    input  rtab_dep_pkg::rtab_deps_t  alloc_deps_i,

    output logic                      empty_o,
    output logic                      full_o,

    output logic                      pop_try_valid_o,
    input  logic                      pop_try_i,
    output rtab_cfg_pkg::rtab_req_t   pop_try_req_o,
    output rtab_cfg_pkg::rtab_ptr_t   pop_try_ptr_o,

    input  logic                      pop_commit_i,
    input  rtab_cfg_pkg::rtab_ptr_t   pop_commit_ptr_i,
    input  logic                      pop_rback_i,
    input  rtab_cfg_pkg::rtab_ptr_t   pop_rback_ptr_i,

    input  logic                      miss_ready_i,
    input  logic                      refill_i,
    input  rtab_cfg_pkg::rtab_nline_t refill_nline_i,
    input  logic                      flush_ack_i,
    input  rtab_cfg_pkg::rtab_nline_t flush_ack_nline_i
);

    import rtab_cfg_pkg::*;

    rtab_bv_t                      valid;
    rtab_bv_t                      head;
    rtab_bv_t                      tail;
    rtab_bv_t                      alloc_bv;
    rtab_bv_t                      nodeps;
    rtab_bv_t                      pop_try_bv;
    rtab_ptr_t   [RTAB_ENTRIES-1:0] next;
    rtab_nline_t [RTAB_ENTRIES-1:0] nline;
    logic                          line_hit;

    // Hit is only reported while a check is requested
    assign check_hit_o = check_i & line_hit;

    rtab_entry_store u_store (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .check_nline_i    (check_nline_i),
        .check_hit_o      (line_hit),
        .alloc_i          (alloc_i),
        .alloc_link_i     (alloc_link_i),
        .alloc_req_i      (alloc_req_i),
        .pop_try_bv_i     (pop_try_bv),
        .pop_sel_ptr_i    (pop_try_ptr_o),
        .pop_commit_i     (pop_commit_i),
        .pop_commit_ptr_i (pop_commit_ptr_i),
        .pop_rback_i      (pop_rback_i),
        .pop_rback_ptr_i  (pop_rback_ptr_i),
        .empty_o          (empty_o),
        .full_o           (full_o),
        .valid_o          (valid),
        .head_o           (head),
        .tail_o           (tail),
        .alloc_bv_o       (alloc_bv),
        .next_o           (next),
        .nline_o          (nline),
        .pop_req_o        (pop_try_req_o)
    );

    rtab_dep_tracker u_deps (
        .clk_i             (clk_i),
        .rst_ni            (rst_ni),
        .alloc_bv_i        (alloc_bv),
        .alloc_deps_i      (alloc_deps_i),
        .nline_i           (nline),
        .pop_rback_i       (pop_rback_i),
        .pop_rback_ptr_i   (pop_rback_ptr_i),
        .miss_ready_i      (miss_ready_i),
        .refill_i          (refill_i),
        .refill_nline_i    (refill_nline_i),
        .flush_ack_i       (flush_ack_i),
        .flush_ack_nline_i (flush_ack_nline_i),
        .nodeps_o          (nodeps)
    );

    rtab_pop_ctrl u_pop (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .valid_i         (valid),
        .head_i          (head),
        .tail_i          (tail),
        .nodeps_i        (nodeps),
        .next_i          (next),
        .pop_try_i       (pop_try_i),
        .pop_rback_i     (pop_rback_i),
        .pop_try_valid_o (pop_try_valid_o),
        .pop_try_ptr_o   (pop_try_ptr_o),
        .pop_try_bv_o    (pop_try_bv)
    );

endmodule

`default_nettype wire

//--- tb_rtab.sv
// Replay table testbench
`timescale 1ns/1ns
`default_nettype none

module tb_rtab;

    import rtab_cfg_pkg::*;
    import rtab_dep_pkg::*;

    // Directed and random tests need about 400 cycles
    localparam int MAX_CYCLES = 2000;

    logic        clk_i;
    logic        rst_ni;
    logic        check_i;
    rtab_nline_t check_nline_i;
    logic        check_hit_o;
    logic        alloc_i;
    logic        alloc_link_i;
    rtab_req_t   alloc_req_i;
    rtab_deps_t  alloc_deps_i;
    logic        empty_o;
    logic        full_o;
    logic        pop_try_valid_o;
    logic        pop_try_i;
    rtab_req_t   pop_try_req_o;
    rtab_ptr_t   pop_try_ptr_o;
    logic        pop_commit_i;
    rtab_ptr_t   pop_commit_ptr_i;
    logic        pop_rback_i;
    rtab_ptr_t   pop_rback_ptr_i;
    logic        miss_ready_i;
    logic        refill_i;
    rtab_nline_t refill_nline_i;
    logic        flush_ack_i;
    rtab_nline_t flush_ack_nline_i;

    // Outstanding payloads in allocation order
    rtab_req_t   shadow_q[$];
    // Entry index holding each outstanding payload
    int          slot_q[$];
    rtab_bv_t    used_slots;
    string       test_name;
    logic [31:0] lcg_state;
    logic        pop_en;
    logic        in_flight;
    int          rback_mode;
    int          n_accepts;
    int          n_commits;
    int          n_rbacks;

    rtab_top dut0 (.*);

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    function automatic rtab_nline_t line_of(input rtab_req_t req);
        return req[$bits(rtab_req_t)-1 -: NLINE_WIDTH];
    endfunction

    function automatic rtab_deps_t dep_bit(input int k);
        return rtab_deps_t'(1) << k;
    endfunction

    function automatic int front_index(input rtab_nline_t nline);
        for (int i = 0; i < shadow_q.size(); i++) begin
            if (line_of(shadow_q[i]) == nline) begin
                return i;
            end
        end
        return -1;
    endfunction

    // New requests take the lowest free entry
    function automatic int lowest_free(input rtab_bv_t used);
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            if (!used[i]) begin
                return i;
            end
        end
        return -1;
    endfunction

    // Oldest outstanding payload of the popped line
    function automatic rtab_req_t expected_pop(input rtab_nline_t nline);
        int idx;
        idx = front_index(nline);
        if (idx < 0) begin
            return '0;
        end
        return shadow_q[idx];
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("TESTBENCH FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (exp == act)
        else report_error($sformatf("ERR %s: %s expected %0h actual %0h",
                                    test_name, what, exp, act));
    endtask

    initial begin
        int cycle_cnt;
        cycle_cnt = 0;
        forever begin
            @(posedge clk_i);
            cycle_cnt++;
            if (cycle_cnt >= MAX_CYCLES) begin
                report_error($sformatf("Timeout in %s after %0d cycles", test_name, cycle_cnt));
            end
        end
    end

    // Checks each accepted pop, then commits or rolls it back
    initial begin : pop_compare
        rtab_nline_t line;
        rtab_ptr_t   ptr;
        int          idx;
        logic        accepted;
        logic        try_next;
        logic        rback;
        pop_try_i        = 1'b0;
        pop_commit_i     = 1'b0;
        pop_commit_ptr_i = '0;
        pop_rback_i      = 1'b0;
        pop_rback_ptr_i  = '0;
        in_flight        = 1'b0;
        n_accepts        = 0;
        n_commits        = 0;
        n_rbacks         = 0;
        ptr              = '0;
        forever begin
            @(negedge clk_i);
            accepted  = rst_ni && pop_try_i && pop_try_valid_o;
            try_next  = pop_en && !accepted;
            in_flight = accepted;
            rback     = 1'b0;
            if (accepted) begin
                line = line_of(pop_try_req_o);
                ptr  = pop_try_ptr_o;
                idx  = front_index(line);
                assert (idx >= 0)
                else report_error($sformatf("%s: pop of line %0h that has no request",
                                            test_name, line));
                check_value("pop payload", 32'(expected_pop(line)), 32'(pop_try_req_o));
                check_value("pop pointer", 32'(slot_q[idx]), 32'(ptr));
                n_accepts++;
                // Mode 1 rolls back the next pop, mode 2 every third pop
                rback = (rback_mode == 1) || (rback_mode == 2 && n_accepts % 3 == 0);
                if (rback) begin
                    n_rbacks++;
                end else begin
                    used_slots[slot_q[idx]] = 1'b0;
                    shadow_q.delete(idx);
                    slot_q.delete(idx);
                    n_commits++;
                end
            end
            @(posedge clk_i);
            #1;
            pop_try_i        = try_next;
            pop_commit_i     = accepted && !rback;
            pop_commit_ptr_i = ptr;
            pop_rback_i      = accepted && rback;
            pop_rback_ptr_i  = ptr;
        end
    end

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
    endtask

    task automatic expect_check(input rtab_nline_t line, input logic exp_hit);
        check_i       = 1'b1;
        check_nline_i = line;
        #1;
        check_value("check hit", 32'(exp_hit), 32'(check_hit_o));
        next_cycle();
        check_i = 1'b0;
    endtask

    // Links the request when its line already has a list
    task automatic alloc_req(input rtab_nline_t line, input rtab_deps_t deps);
        rtab_req_t req;
        logic      hit;
        int        slot;
        check_value("full before allocate", 32'd0, 32'(full_o));
        lcg_state     = lcg_next(lcg_state);
        req           = {line, lcg_state[19:16], lcg_state[27:20]};
        hit           = front_index(line) >= 0;
        slot          = lowest_free(used_slots);
        check_i       = 1'b1;
        check_nline_i = line;
        alloc_i       = !hit;
        alloc_link_i  = hit;
        alloc_req_i   = req;
        alloc_deps_i  = deps;
        used_slots[slot] = 1'b1;
        shadow_q.push_back(req);
        slot_q.push_back(slot);
        #1;
        check_value("check hit on allocate", 32'(hit), 32'(check_hit_o));
        next_cycle();
        check_i      = 1'b0;
        alloc_i      = 1'b0;
        alloc_link_i = 1'b0;
        alloc_deps_i = '0;
    endtask

    task automatic pause_pops();
        pop_en = 1'b0;
        next_cycle();
        while (in_flight) begin
            next_cycle();
        end
    endtask

    task automatic wait_commits(input int target);
        while (n_commits < target) begin
            next_cycle();
        end
    endtask

    task automatic expect_not_offered(input int cycles);
        repeat (cycles) begin
            next_cycle();
            check_value("pop offered", 32'd0, 32'(pop_try_valid_o));
        end
    endtask

    task automatic pulse_refill(input rtab_nline_t line);
        refill_i       = 1'b1;
        refill_nline_i = line;
        next_cycle();
        refill_i = 1'b0;
    endtask

    task automatic pulse_flush_ack(input rtab_nline_t line);
        flush_ack_i       = 1'b1;
        flush_ack_nline_i = line;
        next_cycle();
        flush_ack_i = 1'b0;
    endtask

    initial begin : stimulus
        int burst;
        rst_ni            = 1'b0;
        check_i           = 1'b0;
        check_nline_i     = '0;
        alloc_i           = 1'b0;
        alloc_link_i      = 1'b0;
        alloc_req_i       = '0;
        alloc_deps_i      = '0;
        miss_ready_i      = 1'b0;
        refill_i          = 1'b0;
        refill_nline_i    = '0;
        flush_ack_i       = 1'b0;
        flush_ack_nline_i = '0;
        used_slots        = '0;
        lcg_state         = 32'd19;
        pop_en            = 1'b0;
        rback_mode        = 0;
        test_name         = "reset";
        repeat (3) @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        test_name = "fill and check";
        check_value("empty after reset", 32'd1, 32'(empty_o));
        expect_check(8'h10, 1'b0);
        for (int i = 0; i < RTAB_ENTRIES; i++) begin
            alloc_req(8'h10 + rtab_nline_t'(i), '0);
        end
        check_value("full", 32'd1, 32'(full_o));
        // No hit is reported while no check is requested
        check_nline_i = 8'h12;
        #1;
        check_value("hit without check", 32'd0, 32'(check_hit_o));
        next_cycle();
        expect_check(8'h12, 1'b1);
        expect_check(8'h20, 1'b0);

        test_name = "plain replay";
        pop_en = 1'b1;
        wait_commits(4);
        pause_pops();
        check_value("empty after commits", 32'd1, 32'(empty_o));

        test_name = "list order";
        alloc_req(8'h30, '0);
        alloc_req(8'h31, '0);
        alloc_req(8'h30, '0);
        alloc_req(8'h30, '0);
        pop_en = 1'b1;
        wait_commits(n_commits + 4);
        pause_pops();

        test_name = "pending miss";
        alloc_req(8'h40, dep_bit(DEP_MSHR_HIT));
        pop_en = 1'b1;
        expect_not_offered(4);
        pulse_refill(8'h41);
        expect_not_offered(3);
        pulse_refill(8'h40);
        wait_commits(n_commits + 1);
        pause_pops();

        test_name = "miss not ready";
        alloc_req(8'h42, dep_bit(DEP_MISS_READY));
        pop_en = 1'b1;
        expect_not_offered(3);
        miss_ready_i = 1'b1;
        next_cycle();
        miss_ready_i = 1'b0;
        wait_commits(n_commits + 1);
        pause_pops();

        test_name = "flush after rollback";
        alloc_req(8'h50, '0);
        // Rollback re-arms the flags from the allocate-side inputs
        alloc_deps_i = dep_bit(DEP_FLUSH_HIT);
        rback_mode   = 1;
        pop_en       = 1'b1;
        while (n_rbacks == 0) begin
            next_cycle();
        end
        rback_mode = 0;
        expect_not_offered(4);
        alloc_deps_i = '0;
        pulse_flush_ack(8'h51);
        expect_not_offered(3);
        pulse_flush_ack(8'h50);
        wait_commits(n_commits + 1);
        pause_pops();

        test_name  = "random mix";
        rback_mode = 2;
        for (int round = 0; round < 24; round++) begin
            pause_pops();
            lcg_state = lcg_next(lcg_state);
            burst     = 1 + int'(lcg_state[17:16]) % 3;
            repeat (burst) begin
                lcg_state = lcg_next(lcg_state);
                if (shadow_q.size() < RTAB_ENTRIES) begin
                    alloc_req(8'h60 + rtab_nline_t'(lcg_state[21:20]), '0);
                end else begin
                    check_value("full in mix", 32'd1, 32'(full_o));
                end
            end
            pop_en = 1'b1;
            repeat (6) next_cycle();
        end
        pop_en = 1'b1;
        while (shadow_q.size() != 0) begin
            next_cycle();
        end
        pause_pops();
        check_value("empty after drain", 32'd1, 32'(empty_o));

        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
rtab_cfg_pkg.sv
rtab_dep_pkg.sv
rtab_entry_store.sv
rtab_dep_tracker.sv
rtab_pop_ctrl.sv
rtab_top.sv
tb_rtab.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the replay table testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_rtab -Mdir obj_dir -f all.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "Verilator build failed with status $build_status"
    exit 1
fi

./obj_dir/Vtb_rtab
sim_status=$?
if [ $sim_status -ne 0 ]; then
    echo "Simulation failed with status $sim_status"
    exit $sim_status
fi
exit 0
